// ==== common/icache_pkg.sv ====
/*
 * instruction cache geometry constants
 * controller state codes
 * request address union, raw word or tag/index/offset fields
 */
package icache_pkg;

    // line and set geometry
    localparam int ADDR_W         = 32;
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;
    localparam int NUM_SETS       = 256;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = 128;

    // byte bits inside a word, below the word select
    localparam int BYTE_OFF_W     = 2;
    localparam int WORD_SEL_W     = OFFSET_W - BYTE_OFF_W;

    // controller state encoding
    localparam int         STATE_W   = 2;
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_LOOKUP = 2'd1;
    localparam logic [1:0] ST_MISS   = 2'd2;
    localparam logic [1:0] ST_REFILL = 2'd3;

    // request address
    // raw goes out on the bus, f is used for lookup and word select
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } f;
    } icache_addr_u;

endpackage

// ==== icache/icache.sv ====
/*
 * two-way instruction cache top
 * controller, two ways and LRU replacement
 */
`timescale 1ns/10ps

module icache (
    input  logic                            clk,
    input  logic                            reset,
    // CPU side
    input  logic                            valid,
    input  logic [icache_pkg::TAG_W-1:0]    tag,
    input  logic [icache_pkg::INDEX_W-1:0]  index,
    input  logic [icache_pkg::OFFSET_W-1:0] offset,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic [icache_pkg::WORD_W-1:0]   rdata,
    // bus side
    output logic                            rd_req,
    output logic [icache_pkg::ADDR_W-1:0]   rd_addr,
    input  logic                            rd_rdy,
    input  logic                            ret_valid,
    input  logic [icache_pkg::LINE_W-1:0]   ret_data
);

    logic [1:0]                     way_hit;
    logic                           way0_valid;
    logic [icache_pkg::LINE_W-1:0]  way0_block;
    logic [icache_pkg::LINE_W-1:0]  way1_block;
    logic [icache_pkg::INDEX_W-1:0] lookup_index;
    logic [icache_pkg::INDEX_W-1:0] buf_index;
    logic [icache_pkg::TAG_W-1:0]   buf_tag;
    logic [1:0]                     fill;
    logic [icache_pkg::LINE_W-1:0]  fill_line;
    logic                           touch;
    logic                           touch_way;
    logic                           way0_valid_miss;
    logic                           victim;

    icache_ctrl ctrl (
        .clk             (clk),
        .reset           (reset),
        .valid           (valid),
        .tag             (tag),
        .index           (index),
        .offset          (offset),
        .addr_ok         (addr_ok),
        .data_ok         (data_ok),
        .rdata           (rdata),
        .rd_req          (rd_req),
        .rd_addr         (rd_addr),
        .rd_rdy          (rd_rdy),
        .ret_valid       (ret_valid),
        .ret_data        (ret_data),
        .way_hit         (way_hit),
        .way0_valid      (way0_valid),
        .way0_block      (way0_block),
        .way1_block      (way1_block),
        .lookup_index    (lookup_index),
        .buf_index       (buf_index),
        .buf_tag         (buf_tag),
        .fill            (fill),
        .fill_line       (fill_line),
        .touch           (touch),
        .touch_way       (touch_way),
        .way0_valid_miss (way0_valid_miss),
        .victim          (victim)
    );

    icache_way way0 (
        .clk        (clk),
        .reset      (reset),
        .rd_index   (lookup_index),
        .req_tag    (buf_tag),
        .fill       (fill[0]),
        .fill_index (buf_index),
        .fill_tag   (buf_tag),
        .fill_line  (fill_line),
        .hit        (way_hit[0]),
        .line_valid (way0_valid),
        .block      (way0_block)
    );

    // way 1 validity not needed, victim logic only looks at way 0
    icache_way way1 (
        .clk        (clk),
        .reset      (reset),
        .rd_index   (lookup_index),
        .req_tag    (buf_tag),
        .fill       (fill[1]),
        .fill_index (buf_index),
        .fill_tag   (buf_tag),
        .fill_line  (fill_line),
        .hit        (way_hit[1]),
        .line_valid (),
        .block      (way1_block)
    );

    icache_replace replace (
        .clk             (clk),
        .reset           (reset),
        .index           (buf_index),
        .touch           (touch),
        .touch_way       (touch_way),
        .way0_valid_miss (way0_valid_miss),
        .victim          (victim)
    );

endmodule

// ==== icache/icache_ctrl.sv ====
/*
 * cache controller
 * lookup and refill FSM, request buffer
 * CPU and bus handshakes, read data word select
 */
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    // CPU side
    input  logic                           valid,
    input  logic [icache_pkg::TAG_W-1:0]   tag,
    input  logic [icache_pkg::INDEX_W-1:0] index,
    input  logic [icache_pkg::OFFSET_W-1:0] offset,
    output logic                           addr_ok,
    output logic                           data_ok,
    output logic [icache_pkg::WORD_W-1:0]  rdata,
    // bus side
    output logic                           rd_req,
    output logic [icache_pkg::ADDR_W-1:0]  rd_addr,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic [icache_pkg::LINE_W-1:0]  ret_data,
    // way side
    input  logic [1:0]                     way_hit,
    input  logic                           way0_valid,
    input  logic [icache_pkg::LINE_W-1:0]  way0_block,
    input  logic [icache_pkg::LINE_W-1:0]  way1_block,
    output logic [icache_pkg::INDEX_W-1:0] lookup_index,
    output logic [icache_pkg::INDEX_W-1:0] buf_index,
    output logic [icache_pkg::TAG_W-1:0]   buf_tag,
    output logic [1:0]                     fill,
    output logic [icache_pkg::LINE_W-1:0]  fill_line,
    // replacement side
    output logic                           touch,
    output logic                           touch_way,
    output logic                           way0_valid_miss,
    input  logic                           victim
);

    logic [icache_pkg::STATE_W-1:0]    state;
    logic [icache_pkg::STATE_W-1:0]    state_nxt;
    icache_pkg::icache_addr_u          req_buf;
    logic                              lookup_hit;
    logic                              lookup_miss;
    logic                              accept;
    logic                              fill_done;
    logic [icache_pkg::LINE_W-1:0]     hit_line;
    logic [icache_pkg::LINE_W-1:0]     sel_line;
    logic [icache_pkg::WORD_SEL_W-1:0] word_sel;

    // lookup result, RAM data belongs to req_buf here
    assign lookup_hit  = (state == icache_pkg::ST_LOOKUP) && (|way_hit);
    assign lookup_miss = (state == icache_pkg::ST_LOOKUP) && !(|way_hit);
    assign fill_done   = (state == icache_pkg::ST_REFILL) && ret_valid;

    // CPU handshake
    // a hit frees the pipe for the next request in the same cycle
    assign addr_ok = (state == icache_pkg::ST_IDLE) || lookup_hit;
    assign accept  = valid && addr_ok;
    assign data_ok = lookup_hit || fill_done;

    // state register
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= icache_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            icache_pkg::ST_IDLE: begin
                if (accept) begin
                    state_nxt = icache_pkg::ST_LOOKUP;
                end
            end
            icache_pkg::ST_LOOKUP: begin
                if (|way_hit) begin
                    state_nxt = valid ? icache_pkg::ST_LOOKUP : icache_pkg::ST_IDLE;
                end else begin
                    // request already out in this cycle
                    state_nxt = rd_rdy ? icache_pkg::ST_REFILL : icache_pkg::ST_MISS;
                end
            end
            icache_pkg::ST_MISS: begin
                if (rd_rdy) begin
                    state_nxt = icache_pkg::ST_REFILL;
                end
            end
            icache_pkg::ST_REFILL: begin
                if (ret_valid) begin
                    state_nxt = icache_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = icache_pkg::ST_IDLE;
            end
        endcase
    end

    // request buffer, only loaded on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf.f.tag    <= tag;
            req_buf.f.index  <= index;
            req_buf.f.offset <= offset;
        end
    end

    // way 0 validity taken at the miss, used for the victim
    always_ff @(posedge clk) begin
        if (reset) begin
            way0_valid_miss <= 1'b0;
        end else if (lookup_miss) begin
            way0_valid_miss <= way0_valid;
        end
    end

    // RAM read follows the incoming request when one is taken
    assign lookup_index = accept ? index : req_buf.f.index;
    assign buf_index    = req_buf.f.index;
    assign buf_tag      = req_buf.f.tag;

    // bus read, whole line at offset zero
    assign rd_req  = lookup_miss || (state == icache_pkg::ST_MISS);
    assign rd_addr = {req_buf.raw[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                      {icache_pkg::OFFSET_W{1'b0}}};

    // refill goes to the victim way in the return cycle
    assign fill      = fill_done ? (victim ? 2'b10 : 2'b01) : 2'b00;
    assign fill_line = ret_data;

    // LRU update on hit and on fill
    assign touch     = lookup_hit || fill_done;
    assign touch_way = fill_done ? victim : way_hit[1];

    // word select, from the hit way or straight from the bus
    assign word_sel = req_buf.f.offset[icache_pkg::OFFSET_W-1:icache_pkg::BYTE_OFF_W];
    assign hit_line = way_hit[1] ? way1_block : way0_block;
    assign sel_line = (state == icache_pkg::ST_REFILL) ? ret_data : hit_line;
    assign rdata    = sel_line[word_sel*icache_pkg::WORD_W +: icache_pkg::WORD_W];

    // bus request held with a steady address until taken
    a_rd_req_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr));

    // line return only while waiting for it
    a_ret_in_refill: assert property (@(posedge clk) disable iff (reset)
        ret_valid |-> state == icache_pkg::ST_REFILL);

    // a line is never resident in both ways
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        state == icache_pkg::ST_LOOKUP |-> $onehot0(way_hit));

endmodule

// ==== icache/icache_replace.sv ====
/*
 * replacement for the two-way cache
 * one LRU bit per set, victim choice for refills
 */
`timescale 1ns/10ps

module icache_replace (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [icache_pkg::INDEX_W-1:0] index,
    input  logic                           touch,
    input  logic                           touch_way,
    input  logic                           way0_valid_miss,
    output logic                           victim
);

    // lru[set] names the least recently used way
    logic [icache_pkg::NUM_SETS-1:0] lru;

    // hit or fill makes the other way the older one
    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (touch) begin
            lru[index] <= ~touch_way;
        end
    end

    // empty way 0 is filled first
    // way 1 gets its turn through the LRU bit after that
    assign victim = way0_valid_miss ? lru[index] : 1'b0;

endmodule

// ==== icache/icache_way.sv ====
/*
 * one cache way
 * tag RAM, four word banks, per-set valid bits
 * hit compare against the buffered request tag
 */
`timescale 1ns/10ps

module icache_way (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    input  logic [icache_pkg::TAG_W-1:0]   req_tag,
    input  logic                           fill,
    input  logic [icache_pkg::INDEX_W-1:0] fill_index,
    input  logic [icache_pkg::TAG_W-1:0]   fill_tag,
    input  logic [icache_pkg::LINE_W-1:0]  fill_line,
    output logic                           hit,
    output logic                           line_valid,
    output logic [icache_pkg::LINE_W-1:0]  block
);

    logic [icache_pkg::INDEX_W-1:0]  ram_addr;
    logic [icache_pkg::TAG_W-1:0]    tag_q;
    logic [icache_pkg::NUM_SETS-1:0] valid_bits;
    logic                            valid_q;

    // fill owns the port for its cycle
    assign ram_addr = fill ? fill_index : rd_index;

    // valid bits live in flops so reset can clear them
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    // valid read lines up with the RAM output
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (fill) begin
            valid_q <= 1'b1;
        end else begin
            valid_q <= valid_bits[ram_addr];
        end
    end

    ram_tag tag_ram (
        .clk   (clk),
        .wen   (fill),
        .addr  (ram_addr),
        .wdata (fill_tag),
        .rdata (tag_q)
    );

    // one bank per word of the line
    for (genvar i = 0; i < icache_pkg::WORDS_PER_LINE; i++) begin : g_bank
        ram_bank bank (
            .clk   (clk),
            .wen   (fill),
            .addr  (ram_addr),
            .wdata (fill_line[i*icache_pkg::WORD_W +: icache_pkg::WORD_W]),
            .rdata (block[i*icache_pkg::WORD_W +: icache_pkg::WORD_W])
        );
    end

    // hit only means something in the lookup cycle
    assign hit        = valid_q && (tag_q == req_tag);
    assign line_valid = valid_q;

endmodule

// ==== icache/ram_bank.sv ====
/*
 * word bank RAM, one 32-bit slice of every line
 * single port, synchronous read and write
 */
`timescale 1ns/10ps

module ram_bank (
    input  logic                           clk,
    input  logic                           wen,
    input  logic [icache_pkg::INDEX_W-1:0] addr,
    input  logic [icache_pkg::WORD_W-1:0]  wdata,
    output logic [icache_pkg::WORD_W-1:0]  rdata
);

    // word storage
    logic [icache_pkg::WORD_W-1:0] mem [icache_pkg::NUM_SETS];

    // write first, then registered read
    // refill data is visible right after the write
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata     <= mem[addr];
        end
    end

endmodule

// ==== icache/ram_tag.sv ====
/*
 * tag RAM, one entry per set
 * single port, synchronous read and write
 */
`timescale 1ns/10ps

module ram_tag (
    input  logic                           clk,
    input  logic                           wen,
    input  logic [icache_pkg::INDEX_W-1:0] addr,
    input  logic [icache_pkg::TAG_W-1:0]   wdata,
    output logic [icache_pkg::TAG_W-1:0]   rdata
);

    // storage array
    logic [icache_pkg::TAG_W-1:0] mem [icache_pkg::NUM_SETS];

    // registered read port
    // a write shows the new tag on rdata next cycle
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata     <= mem[addr];
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing --timescale 1ns/10ps \
    -f tb.f --top-module tb_icache -o tb_icache \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_icache > sim.log 2>&1 || echo "simulation exited with an error"
cat sim.log

grep -qx "TESTS PASSED" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

// ==== tb.f ====
common/icache_pkg.sv
icache/ram_tag.sv
icache/ram_bank.sv
icache/icache_way.sv
icache/icache_replace.sv
icache/icache_ctrl.sv
icache/icache.sv
verif/tb_clkgen.sv
verif/tb_icache.sv

// ==== verif/tb_clkgen.sv ====
/*
 * testbench clock source
 * free running, 100 ns period
 */
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk
);

    // low first, rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever begin
            // half of the 100 ns period
            #50 clk = ~clk;
        end
    end

endmodule

// ==== verif/tb_icache.sv ====
/*
 * testbench for the two-way instruction cache
 * CPU stimulus, bus responder, reference model
 * immediate assertions check every response
 */
`timescale 1ns/10ps

module tb_icache;

    // cycles any wait may take before the run is stopped
    localparam int WAIT_LIMIT = 20;

    // replacement test tags, all used at one set
    localparam logic [19:0] TAG_A = 20'ha1234;
    localparam logic [19:0] TAG_B = 20'hb5678;
    localparam logic [19:0] TAG_C = 20'hc9abc;

    logic                            clk;
    logic                            reset;
    logic                            valid;
    logic [icache_pkg::TAG_W-1:0]    tag;
    logic [icache_pkg::INDEX_W-1:0]  index;
    logic [icache_pkg::OFFSET_W-1:0] offset;
    logic                            addr_ok;
    logic                            data_ok;
    logic [icache_pkg::WORD_W-1:0]   rdata;
    logic                            rd_req;
    logic [icache_pkg::ADDR_W-1:0]   rd_addr;
    logic                            rd_rdy;
    logic                            ret_valid;
    logic [icache_pkg::LINE_W-1:0]   ret_data;

    // model: tags and valid bits per way, one LRU bit per set
    logic [19:0]  model_tag0 [icache_pkg::NUM_SETS];
    logic [19:0]  model_tag1 [icache_pkg::NUM_SETS];
    logic [255:0] model_valid0;
    logic [255:0] model_valid1;
    logic [255:0] model_lru;

    // addresses of one back-to-back hit burst
    logic [31:0] burst_q [$];

    tb_clkgen clkgen_i (.clk(clk));

    icache dut_i (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        stop_run();
    endtask

    task automatic timed_out(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        stop_run();
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else mismatch(name, exp, act);
    endtask

    // memory contents, a hash of the word address
    function automatic logic [31:0] mix_word(input logic [31:0] word_addr);
        logic [31:0] h;
        h = word_addr * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h ^ {word_addr[15:0], word_addr[31:16]};
        return h ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return mix_word({2'b00, addr[31:2]});
    endfunction

    // word 0 of the line in the low bits
    function automatic logic [127:0] line_for(input logic [31:0] addr);
        logic [31:0] base;
        base = {2'b00, addr[31:4], 2'b00};
        return {mix_word(base + 32'd3), mix_word(base + 32'd2),
                mix_word(base + 32'd1), mix_word(base)};
    endfunction

    function automatic logic [31:0] make_addr(input logic [19:0] t, input logic [7:0] s,
                                              input logic [3:0] o);
        return {t, s, o};
    endfunction

    // -1 on a predicted miss
    function automatic int model_hit_way(input logic [31:0] addr);
        logic [7:0] set;
        set = addr[11:4];
        if (model_valid0[set] && model_tag0[set] == addr[31:12]) begin
            return 0;
        end
        if (model_valid1[set] && model_tag1[set] == addr[31:12]) begin
            return 1;
        end
        return -1;
    endfunction

    // the other way becomes least recently used
    task automatic model_touch(input logic [31:0] addr, input int way);
        model_lru[addr[11:4]] = (way == 0);
    endtask

    task automatic model_fill(input logic [31:0] addr);
        logic [7:0] set;
        logic       victim;
        set = addr[11:4];
        // empty way 0 first, else the LRU way
        victim = model_valid0[set] ? model_lru[set] : 1'b0;
        if (victim) begin
            model_tag1[set]   = addr[31:12];
            model_valid1[set] = 1'b1;
        end else begin
            model_tag0[set]   = addr[31:12];
            model_valid0[set] = 1'b1;
        end
        model_lru[set] = ~victim;
    endtask

    task automatic drive_request(input logic [31:0] addr);
        valid  = 1'b1;
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
    endtask

    // request held until addr_ok, taken at the next rising edge
    task automatic wait_accept(input string name);
        int cycles;
        cycles = 0;
        #1;
        while (!addr_ok) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                timed_out({name, " request accept"});
            end
            @(negedge clk);
            #1;
        end
    endtask

    // bus side of one miss, entered in the lookup cycle
    task automatic serve_line(input logic [31:0] addr, input string name, input int stall,
                              input bit poke);
        int          stall_cycles;
        int          ret_delay;
        logic [31:0] held_addr;
        stall_cycles = (stall < 0) ? int'($urandom % 6) : stall;
        ret_delay    = 1 + int'($urandom % 8);
        held_addr    = {addr[31:4], 4'h0};
        for (int i = 0; i < stall_cycles; i++) begin
            @(negedge clk);
            // a new request must not slip in while the bus is stalled
            if (poke) begin
                drive_request(addr ^ 32'h0000_1000);
            end
            #1;
            check_bit({name, " addr_ok in stall"}, 1'b0, addr_ok);
            check_bit({name, " rd_req in stall"}, 1'b1, rd_req);
            compare_word({name, " rd_addr in stall"}, held_addr, rd_addr);
        end
        // transfer cycle
        @(negedge clk);
        valid  = 1'b0;
        rd_rdy = 1'b1;
        #1;
        check_bit({name, " rd_req at transfer"}, 1'b1, rd_req);
        compare_word({name, " rd_addr at transfer"}, held_addr, rd_addr);
        @(negedge clk);
        rd_rdy = 1'b0;
        for (int i = 1; i < ret_delay; i++) begin
            #1;
            check_bit({name, " rd_req in refill"}, 1'b0, rd_req);
            check_bit({name, " addr_ok in refill"}, 1'b0, addr_ok);
            check_bit({name, " data_ok in refill"}, 1'b0, data_ok);
            @(negedge clk);
        end
        // whole line in one beat
        ret_valid = 1'b1;
        ret_data  = line_for(addr);
        #1;
        check_bit({name, " data_ok on return"}, 1'b1, data_ok);
        compare_word({name, " rdata on return"}, expected_word(addr), rdata);
        @(negedge clk);
        ret_valid = 1'b0;
        ret_data  = '0;
        #1;
        check_bit({name, " addr_ok after refill"}, 1'b1, addr_ok);
        check_bit({name, " data_ok after refill"}, 1'b0, data_ok);
    endtask

    // one request, hit or miss as the model predicts
    task automatic access(input logic [31:0] addr, input string name, input int stall,
                          input bit poke);
        int way;
        way = model_hit_way(addr);
        @(negedge clk);
        drive_request(addr);
        wait_accept(name);
        @(negedge clk);
        valid = 1'b0;
        #1;
        if (way >= 0) begin
            check_bit({name, " data_ok"}, 1'b1, data_ok);
            compare_word({name, " rdata"}, expected_word(addr), rdata);
            check_bit({name, " rd_req"}, 1'b0, rd_req);
            model_touch(addr, way);
        end else begin
            check_bit({name, " data_ok"}, 1'b0, data_ok);
            check_bit({name, " addr_ok"}, 1'b0, addr_ok);
            check_bit({name, " rd_req"}, 1'b1, rd_req);
            compare_word({name, " rd_addr"}, {addr[31:4], 4'h0}, rd_addr);
            serve_line(addr, name, stall, poke);
            model_fill(addr);
        end
    endtask

    // one request per cycle, each answered in the next
    task automatic pipe_hits(input string name);
        int n;
        n = burst_q.size();
        @(negedge clk);
        drive_request(burst_q[0]);
        wait_accept(name);
        for (int i = 1; i <= n; i++) begin
            @(negedge clk);
            if (i < n) begin
                drive_request(burst_q[i]);
            end else begin
                valid = 1'b0;
            end
            #1;
            check_bit({name, " data_ok"}, 1'b1, data_ok);
            compare_word({name, " rdata"}, expected_word(burst_q[i-1]), rdata);
            check_bit({name, " rd_req"}, 1'b0, rd_req);
            if (i < n) begin
                check_bit({name, " addr_ok"}, 1'b1, addr_ok);
            end
            model_touch(burst_q[i-1], model_hit_way(burst_q[i-1]));
        end
    endtask

    initial begin
        logic [19:0] t;
        logic [7:0]  s;
        int          pick;
        void'($urandom(63343));
        reset        = 1'b1;
        valid        = 1'b0;
        tag          = '0;
        index        = '0;
        offset       = '0;
        rd_rdy       = 1'b0;
        ret_valid    = 1'b0;
        ret_data     = '0;
        model_valid0 = '0;
        model_valid1 = '0;
        model_lru    = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;

        // state after reset
        check_bit("reset data_ok", 1'b0, data_ok);
        check_bit("reset rd_req", 1'b0, rd_req);
        check_bit("reset addr_ok", 1'b1, addr_ok);

        // first touch of a line, then every word of it
        access(32'h0001_2344, "cold miss", -1, 1'b0);
        for (int w = 0; w < 4; w++) begin
            access(32'h0001_2340 + 32'(w * 4), "hit after refill", -1, 1'b0);
        end

        // burst over two resident lines
        access(32'h0001_2350, "burst line fill", -1, 1'b0);
        burst_q = {32'h0001_2340, 32'h0001_2354, 32'h0001_2348, 32'h0001_235c,
                   32'h0001_234c, 32'h0001_2350, 32'h0001_2344, 32'h0001_2358};
        pipe_hits("pipelined hits");

        // three tags fighting over one set
        access(make_addr(TAG_A, 8'h80, 4'h0), "two-way A", -1, 1'b0);
        access(make_addr(TAG_B, 8'h80, 4'h4), "two-way B", -1, 1'b0);
        access(make_addr(TAG_A, 8'h80, 4'h8), "two-way A", -1, 1'b0);
        access(make_addr(TAG_B, 8'h80, 4'hc), "two-way B", -1, 1'b0);
        access(make_addr(TAG_C, 8'h80, 4'h0), "two-way C", -1, 1'b0);
        access(make_addr(TAG_A, 8'h80, 4'h4), "two-way A", -1, 1'b0);
        access(make_addr(TAG_B, 8'h80, 4'h8), "two-way B", -1, 1'b0);
        access(make_addr(TAG_C, 8'h80, 4'hc), "two-way C", -1, 1'b0);
        for (int k = 0; k < 40; k++) begin
            pick = int'($urandom % 3);
            if (pick == 0) begin
                t = TAG_A;
            end else if (pick == 1) begin
                t = TAG_B;
            end else begin
                t = TAG_C;
            end
            s = ($urandom % 2 == 0) ? 8'h80 : 8'h81;
            access(make_addr(t, s, 4'($urandom)), "random replacement", -1, 1'b0);
        end

        // long stall with a request waiting, then a hit on the line
        access(32'h0045_6788, "bus stall", 5, 1'b1);
        access(32'h0045_6784, "hit after stall", -1, 1'b0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule
